//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -j 0
TOP        ?= manycore_xbar_tb
FILELIST   ?= manycore_xbar.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- design/manycore_xbar_top.sv
// ##########################################################################
// Top level of the 2x2 manycore crossbar
// Link adapter, one input buffer per source and the switch core
// ##########################################################################

`timescale 1ns/1ns

module manycore_xbar_top
  import xbar_pkg::*;
  (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,

    input  logic [num_in_lp-1:0]                    link_v_i,
    input  logic [num_in_lp-1:0][link_width_lp-1:0] link_data_i,
    output logic [num_in_lp-1:0]                    link_ready_o,

    output logic [num_in_lp-1:0]                    link_v_o,
    output logic [num_in_lp-1:0][link_width_lp-1:0] link_data_o,
    input  logic [num_in_lp-1:0]                    link_ready_i
  );

  // Adapter to buffers
  logic [num_in_lp-1:0]                    xbar_v;
  logic [num_in_lp-1:0][xbar_width_lp-1:0] xbar_data;
  logic [num_in_lp-1:0]                    xbar_ready;

  // Buffers to switch
  logic [num_in_lp-1:0]                    head_v;
  logic [num_in_lp-1:0][xbar_width_lp-1:0] head_data;
  logic [num_in_lp-1:0]                    head_yumi;

  // Switch back to adapter
  logic [num_in_lp-1:0]                    out_v;
  logic [num_in_lp-1:0][xbar_width_lp-1:0] out_data;
  logic [num_in_lp-1:0]                    out_ready;

  mc_link_to_xbar link (
    .link_v_i     (link_v_i),
    .link_data_i  (link_data_i),
    .link_ready_o (link_ready_o),
    .link_v_o     (link_v_o),
    .link_data_o  (link_data_o),
    .link_ready_i (link_ready_i),
    .xbar_v_o     (xbar_v),
    .xbar_data_o  (xbar_data),
    .xbar_ready_i (xbar_ready),
    .xbar_v_i     (out_v),
    .xbar_data_i  (out_data),
    .xbar_ready_o (out_ready)
  );

  for (genvar p = 0; p < num_in_lp; p++) begin : g_in_buf
    xbar_in_fifo in_buf (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .v_i     (xbar_v[p]),
      .data_i  (xbar_data[p]),
      .ready_o (xbar_ready[p]),
      .v_o     (head_v[p]),
      .data_o  (head_data[p]),
      .yumi_i  (head_yumi[p])
    );
  end

  xbar_switch switch_core (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_v_i      (head_v),
    .in_data_i   (head_data),
    .in_yumi_o   (head_yumi),
    .out_v_o     (out_v),
    .out_data_o  (out_data),
    .out_ready_i (out_ready)
  );

endmodule

//--- design/mc_link_to_xbar.sv
// ##########################################################################
// Link adapter between manycore tiles and the crossbar
// Inbound  : x/y destination coordinates folded into a flat index
// Outbound : flat source index split back into x/y coordinates
// Valid and ready travel straight through in both directions
// ##########################################################################

`timescale 1ns/1ns

module mc_link_to_xbar
  import xbar_pkg::*;
  (
    // Tile side
    input  logic [num_in_lp-1:0]                    link_v_i,
    input  logic [num_in_lp-1:0][link_width_lp-1:0] link_data_i,
    output logic [num_in_lp-1:0]                    link_ready_o,

    output logic [num_in_lp-1:0]                    link_v_o,
    output logic [num_in_lp-1:0][link_width_lp-1:0] link_data_o,
    input  logic [num_in_lp-1:0]                    link_ready_i,

    // Crossbar side
    output logic [num_in_lp-1:0]                    xbar_v_o,
    output logic [num_in_lp-1:0][xbar_width_lp-1:0] xbar_data_o,
    input  logic [num_in_lp-1:0]                    xbar_ready_i,

    input  logic [num_in_lp-1:0]                    xbar_v_i,
    input  logic [num_in_lp-1:0][xbar_width_lp-1:0] xbar_data_i,
    output logic [num_in_lp-1:0]                    xbar_ready_o
  );

  logic [num_in_lp-1:0][x_cord_width_lp-1:0] x_cord_in;
  logic [num_in_lp-1:0][y_cord_width_lp-1:0] y_cord_in;
  logic [num_in_lp-1:0][x_cord_width_lp-1:0] x_cord_out;
  logic [num_in_lp-1:0][y_cord_width_lp-1:0] y_cord_out;
  logic [num_in_lp-1:0][lg_num_in_lp-1:0]    src_idx;

  // Tiles toward crossbar
  for (genvar i = 0; i < num_in_y_lp; i++) begin : g_in_row
    for (genvar j = 0; j < num_in_x_lp; j++) begin : g_in_col

      assign x_cord_in[i*num_in_x_lp+j] = link_data_i[i*num_in_x_lp+j][0+:x_cord_width_lp];
      assign y_cord_in[i*num_in_x_lp+j] =
        link_data_i[i*num_in_x_lp+j][x_cord_width_lp+:y_cord_width_lp];

      assign xbar_data_o[i*num_in_x_lp+j] = {
        link_data_i[i*num_in_x_lp+j][link_width_lp-1:x_cord_width_lp+y_cord_width_lp],
        lg_num_in_lp'(x_cord_in[i*num_in_x_lp+j]
                      + y_cord_in[i*num_in_x_lp+j] * num_in_x_lp)
      };

      assign xbar_v_o[i*num_in_x_lp+j]     = link_v_i[i*num_in_x_lp+j];
      assign link_ready_o[i*num_in_x_lp+j] = xbar_ready_i[i*num_in_x_lp+j];
    end
  end

  // Crossbar toward tiles where the low bits name the sender
  for (genvar i = 0; i < num_in_y_lp; i++) begin : g_out_row
    for (genvar j = 0; j < num_in_x_lp; j++) begin : g_out_col

      assign src_idx[i*num_in_x_lp+j] = xbar_data_i[i*num_in_x_lp+j][0+:lg_num_in_lp];

      assign y_cord_out[i*num_in_x_lp+j] =
        y_cord_width_lp'(src_idx[i*num_in_x_lp+j] / num_in_x_lp);
      assign x_cord_out[i*num_in_x_lp+j] =
        x_cord_width_lp'(src_idx[i*num_in_x_lp+j] % num_in_x_lp);

      assign link_data_o[i*num_in_x_lp+j] = {
        xbar_data_i[i*num_in_x_lp+j][xbar_width_lp-1:lg_num_in_lp],
        y_cord_out[i*num_in_x_lp+j],
        x_cord_out[i*num_in_x_lp+j]
      };

      assign link_v_o[i*num_in_x_lp+j]     = xbar_v_i[i*num_in_x_lp+j];
      assign xbar_ready_o[i*num_in_x_lp+j] = link_ready_i[i*num_in_x_lp+j];
    end
  end

endmodule

//--- design/xbar_in_fifo.sv
// ##########################################################################
// Two-entry valid/ready input buffer for one crossbar source
// Head is visible the cycle after a write; a full buffer still accepts
// when the head is popped in the same cycle
// ##########################################################################

`timescale 1ns/1ns

module xbar_in_fifo
  import xbar_pkg::*;
  (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    input  logic                     v_i,
    input  logic [xbar_width_lp-1:0] data_i,
    output logic                     ready_o,

    output logic                     v_o,
    output logic [xbar_width_lp-1:0] data_o,
    input  logic                     yumi_i
  );

  logic [xbar_width_lp-1:0] mem_r [2];
  logic                     wr_ptr_r;
  logic                     rd_ptr_r;
  logic [1:0]               count_r;
  logic                     full;
  logic                     push;
  logic                     pop;

  assign full    = (count_r == 2'd2);
  assign ready_o = ~full | yumi_i;
  assign push    = v_i & ready_o;
  assign pop     = yumi_i;

  assign v_o    = (count_r != 2'd0);
  assign data_o = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (pop) begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count_r <= count_r + 2'd1;
      end else if (pop && !push) begin
        count_r <= count_r - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

endmodule

//--- design/xbar_pkg.sv
// ##########################################################################
// Shared constants for the 2x2 manycore crossbar
// Grid size, coordinate and index widths, link and crossbar packet widths
// ##########################################################################

package xbar_pkg;

  // Grid dimensions
  localparam int num_in_x_lp = 2;
  localparam int num_in_y_lp = 2;
  localparam int num_in_lp   = num_in_x_lp * num_in_y_lp;

  // Flat crossbar index is row times num_in_x_lp plus column
  localparam int lg_num_in_lp = $clog2(num_in_lp);

  // Coordinate fields sit at the bottom of a link packet with x lowest
  localparam int x_cord_width_lp = 2;
  localparam int y_cord_width_lp = 2;

  localparam int payload_width_lp = 12;

  // Link packet is {payload, y, x}
  localparam int link_width_lp = payload_width_lp + y_cord_width_lp + x_cord_width_lp;

  // Crossbar packet is {payload, flat index}
  localparam int xbar_width_lp = payload_width_lp + lg_num_in_lp;

endpackage

//--- design/xbar_rr_arbiter.sv
// ##########################################################################
// Round-robin arbiter for one crossbar destination
// Grants the first requester at or after the pointer; the pointer moves
// past the winner only on an acknowledged transfer
// ##########################################################################

`timescale 1ns/1ns

module xbar_rr_arbiter
  import xbar_pkg::*;
  (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic [num_in_lp-1:0] req_i,
    output logic [num_in_lp-1:0] grant_o,
    input  logic                 ack_i
  );

  logic [lg_num_in_lp-1:0] ptr_r;
  logic [lg_num_in_lp-1:0] cand;
  logic [lg_num_in_lp-1:0] gnt_idx;
  logic                    found;

  // Scan from the pointer, wrapping around
  always_comb begin
    grant_o = '0;
    gnt_idx = '0;
    cand    = '0;
    found   = 1'b0;
    for (int k = 0; k < num_in_lp; k++) begin
      cand = lg_num_in_lp'((ptr_r + k) % num_in_lp);
      if (!found && req_i[cand]) begin
        found         = 1'b1;
        gnt_idx       = cand;
        grant_o[cand] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_r <= '0;
    end else if (ack_i && found) begin
      ptr_r <= lg_num_in_lp'((gnt_idx + 1) % num_in_lp);
    end
  end

endmodule

//--- design/xbar_switch.sv
// ##########################################################################
// Crossbar switch core
// Decodes head destinations into per-destination requests, arbitrates
// each destination, muxes the winner and stamps in its source index
// Pops a source when its destination takes the packet
// ##########################################################################

`timescale 1ns/1ns

module xbar_switch
  import xbar_pkg::*;
  (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,

    input  logic [num_in_lp-1:0]                    in_v_i,
    input  logic [num_in_lp-1:0][xbar_width_lp-1:0] in_data_i,
    output logic [num_in_lp-1:0]                    in_yumi_o,

    output logic [num_in_lp-1:0]                    out_v_o,
    output logic [num_in_lp-1:0][xbar_width_lp-1:0] out_data_o,
    input  logic [num_in_lp-1:0]                    out_ready_i
  );

  // Indexed [destination][source]
  logic [num_in_lp-1:0][num_in_lp-1:0] req;
  logic [num_in_lp-1:0][num_in_lp-1:0] grant;
  logic [num_in_lp-1:0]                ack;

  // Request decode from each head's destination index
  always_comb begin
    req = '0;
    for (int s = 0; s < num_in_lp; s++) begin
      for (int d = 0; d < num_in_lp; d++) begin
        if (in_v_i[s] && (in_data_i[s][0+:lg_num_in_lp] == lg_num_in_lp'(d))) begin
          req[d][s] = 1'b1;
        end
      end
    end
  end

  for (genvar d = 0; d < num_in_lp; d++) begin : g_dest

    assign out_v_o[d] = |req[d];
    assign ack[d]     = out_v_o[d] & out_ready_i[d];

    xbar_rr_arbiter arb (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (req[d]),
      .grant_o (grant[d]),
      .ack_i   (ack[d])
    );

    // One-hot grant selects the payload; index field becomes the sender
    always_comb begin
      out_data_o[d] = '0;
      for (int s = 0; s < num_in_lp; s++) begin
        if (grant[d][s]) begin
          out_data_o[d] = {
            in_data_i[s][xbar_width_lp-1:lg_num_in_lp],
            lg_num_in_lp'(s)
          };
        end
      end
    end
  end

  // A head targets one destination only, so at most one term is set per source
  always_comb begin
    in_yumi_o = '0;
    for (int d = 0; d < num_in_lp; d++) begin
      for (int s = 0; s < num_in_lp; s++) begin
        if (grant[d][s] && out_ready_i[d]) begin
          in_yumi_o[s] = 1'b1;
        end
      end
    end
  end

endmodule

//--- manycore_xbar.f
design/xbar_pkg.sv
design/mc_link_to_xbar.sv
design/xbar_in_fifo.sv
design/xbar_rr_arbiter.sv
design/xbar_switch.sv
design/manycore_xbar_top.sv
verification/manycore_xbar_tb.sv

//--- verification/manycore_xbar_tb.sv
// ##########################################################################
// Testbench for the 2x2 manycore crossbar
// Reset state, single-packet latency, four sources streaming into one
// tile, random traffic under random back-pressure, scoreboard of
// per source/destination queues and a watchdog
// ##########################################################################

`timescale 1ns/1ns

module manycore_xbar_tb
  import xbar_pkg::*;
();

  localparam int clk_period_lp     = 20;
  localparam int reset_cycles_lp   = 16;
  localparam int stream_per_src_lp = 16;
  localparam int rand_per_src_lp   = 60;
  localparam int total_pkts_lp     = 1 + num_in_lp * (stream_per_src_lp + rand_per_src_lp);
  // Enough to empty two full entries per buffer at 40 cycles each
  localparam int drain_cycles_lp   = 40 * 2 * num_in_lp;
  // Up to 40 cycles per packet
  localparam int timeout_cycles_lp = reset_cycles_lp + total_pkts_lp * 40
                                     + 2 * drain_cycles_lp;

  logic                                    clk = 1'b0;
  logic                                    rst_n;
  logic [num_in_lp-1:0]                    src_v;
  logic [num_in_lp-1:0][link_width_lp-1:0] src_data;
  logic [num_in_lp-1:0]                    src_ready;
  logic [num_in_lp-1:0]                    dst_v;
  logic [num_in_lp-1:0][link_width_lp-1:0] dst_data;
  logic [num_in_lp-1:0]                    dst_ready;

  integer seed;
  int     check_count;
  int     mismatch_count;
  int     failure_count;
  int     outstanding;
  int     delivered_count;
  int     stall_count;
  int     rr_last;
  bit     stream_phase;

  // Handshakes that complete at the coming rising edge
  logic [num_in_lp-1:0] in_fire;
  logic [num_in_lp-1:0] out_fire;
  logic [num_in_lp-1:0] src_pending;
  int                   src_left [num_in_lp];

  // Key is source*num_in_lp+destination
  logic [payload_width_lp-1:0] model_q [num_in_lp*num_in_lp][$];

  manycore_xbar_top dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .link_v_i     (src_v),
    .link_data_i  (src_data),
    .link_ready_o (src_ready),
    .link_v_o     (dst_v),
    .link_data_o  (dst_data),
    .link_ready_i (dst_ready)
  );

  always #(clk_period_lp / 2) clk = ~clk;

  task automatic check_value(input string what, input int actual, input int expected);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  function automatic logic [link_width_lp-1:0] make_packet(
    input int                          dst,
    input logic [payload_width_lp-1:0] payload
  );
    logic [x_cord_width_lp-1:0] x;
    logic [y_cord_width_lp-1:0] y;
    x = x_cord_width_lp'(dst % num_in_x_lp);
    y = y_cord_width_lp'(dst / num_in_x_lp);
    return {payload, y, x};
  endfunction

  // Tile number from the coordinate fields or -1 when off the grid
  function automatic int grid_index(input logic [link_width_lp-1:0] pkt);
    int x;
    int y;
    x = int'(pkt[0+:x_cord_width_lp]);
    y = int'(pkt[x_cord_width_lp+:y_cord_width_lp]);
    if (x >= num_in_x_lp || y >= num_in_y_lp) begin
      return -1;
    end
    return y * num_in_x_lp + x;
  endfunction

  // First source after last that still holds a packet for d
  function automatic int next_pending(input int last, input int d);
    int c;
    for (int k = 1; k <= num_in_lp; k++) begin
      c = (last + k) % num_in_lp;
      if (model_q[c*num_in_lp+d].size() != 0) begin
        return c;
      end
    end
    return -1;
  endfunction

  function automatic int packets_left();
    int n;
    n = 0;
    for (int s = 0; s < num_in_lp; s++) begin
      n += src_left[s];
    end
    return n;
  endfunction

  task automatic record_packet(input int s);
    int d;
    d = grid_index(src_data[s]);
    model_q[s*num_in_lp+d].push_back(src_data[s][link_width_lp-1-:payload_width_lp]);
    outstanding++;
  endtask

  task automatic deliver_packet(input int d);
    int                          s;
    logic [payload_width_lp-1:0] expected;
    s = grid_index(dst_data[d]);
    if (s < 0) begin
      failure_count++;
      $display("error at %0t ns: destination %0d got a sender outside the grid", $time, d);
    end else if (model_q[s*num_in_lp+d].size() == 0) begin
      failure_count++;
      $display("error at %0t ns: destination %0d got a packet from source %0d that was never sent",
               $time, d, s);
    end else begin
      if (stream_phase && d == 0) begin
        check_value("source in stream rotation", s, next_pending(rr_last, d));
        rr_last = s;
      end
      expected = model_q[s*num_in_lp+d].pop_front();
      check_value($sformatf("payload from source %0d at destination %0d", s, d),
                  int'(dst_data[d][link_width_lp-1-:payload_width_lp]), int'(expected));
      outstanding--;
      delivered_count++;
    end
  endtask

  // Scoreboard runs at the falling edge where all signals are settled
  always @(negedge clk) begin : monitor
    logic [num_in_lp-1:0] delivered;
    int                   held;
    int                   s;
    if (!rst_n) begin
      in_fire  = '0;
      out_fire = '0;
    end else begin
      in_fire   = src_v & src_ready;
      out_fire  = dst_v & dst_ready;
      delivered = '0;
      for (int d = 0; d < num_in_lp; d++) begin
        s = grid_index(dst_data[d]);
        if (out_fire[d] && s >= 0) begin
          delivered[s] = 1'b1;
        end
      end
      // Ready drops only with two held and none leaving
      for (int i = 0; i < num_in_lp; i++) begin
        held = 0;
        for (int d = 0; d < num_in_lp; d++) begin
          held += model_q[i*num_in_lp+d].size();
        end
        if (held >= 2 && !delivered[i]) begin
          stall_count++;
        end
        check_value($sformatf("link_ready_o[%0d]", i), int'(src_ready[i]),
                    int'(held < 2 || delivered[i]));
      end
      for (int d = 0; d < num_in_lp; d++) begin
        if (out_fire[d]) begin
          deliver_packet(d);
        end
      end
      for (int i = 0; i < num_in_lp; i++) begin
        if (in_fire[i]) begin
          record_packet(i);
        end
      end
    end
  end

  task automatic drive_cycle(input bit stream_mode, input bit rand_ready);
    int                          dst;
    logic [payload_width_lp-1:0] payload;
    for (int s = 0; s < num_in_lp; s++) begin
      // Hold the packet until its handshake completes
      if (!src_pending[s] || in_fire[s]) begin
        if (src_left[s] > 0 && (stream_mode || (($random(seed) & 1) != 0))) begin
          dst            = stream_mode ? 0 : int'($unsigned($random(seed)) % num_in_lp);
          payload        = payload_width_lp'($random(seed));
          src_v[s]      <= 1'b1;
          src_data[s]   <= make_packet(dst, payload);
          src_pending[s] = 1'b1;
          src_left[s]--;
        end else begin
          src_v[s]      <= 1'b0;
          src_pending[s] = 1'b0;
        end
      end
    end
    if (rand_ready) begin
      dst_ready <= num_in_lp'($random(seed) & $random(seed));
    end else begin
      dst_ready <= '1;
    end
  endtask

  task automatic run_traffic(input bit stream_mode, input bit rand_ready, input int per_src);
    int drain;
    for (int s = 0; s < num_in_lp; s++) begin
      src_left[s] = per_src;
    end
    stream_phase = stream_mode;
    rr_last      = num_in_lp - 1;
    do begin
      @(posedge clk);
      drive_cycle(stream_mode, rand_ready);
    end while (src_pending != '0 || packets_left() != 0);
    // Buffered packets get a bounded time to leave
    drain = 0;
    while (outstanding != 0 && drain < drain_cycles_lp) begin
      @(posedge clk);
      drive_cycle(stream_mode, rand_ready);
      drain++;
    end
    stream_phase = 1'b0;
  endtask

  // One packet from tile 0 to the last tile with all destinations ready
  task automatic check_latency();
    @(posedge clk);
    src_v[0]    <= 1'b1;
    src_data[0] <= make_packet(num_in_lp - 1, payload_width_lp'($random(seed)));
    dst_ready   <= '1;
    @(posedge clk);
    while (!in_fire[0]) begin
      @(posedge clk);
    end
    src_v[0] <= 1'b0;
    @(negedge clk);
    check_value("link_v_o one cycle after acceptance", int'(dst_v[num_in_lp-1]), 1);
    @(posedge clk);
    while (outstanding != 0) begin
      @(posedge clk);
    end
  endtask

  initial begin
    seed            = 32'hc32f;
    check_count     = 0;
    mismatch_count  = 0;
    failure_count   = 0;
    outstanding     = 0;
    delivered_count = 0;
    stall_count     = 0;
    rr_last         = num_in_lp - 1;
    stream_phase    = 1'b0;
    src_pending     = '0;
    rst_n           = 1'b0;
    src_v           = '0;
    src_data        = '0;
    dst_ready       = '1;

    repeat (reset_cycles_lp) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("link_v_o after reset", int'(dst_v), 0);
    check_value("link_ready_o after reset", int'(src_ready), int'({num_in_lp{1'b1}}));

    check_latency();
    run_traffic(1'b1, 1'b0, stream_per_src_lp);
    run_traffic(1'b0, 1'b1, rand_per_src_lp);

    check_value("packets still in flight", outstanding, 0);
    check_value("packets delivered", delivered_count, total_pkts_lp);
    for (int k = 0; k < num_in_lp * num_in_lp; k++) begin
      check_value($sformatf("queue %0d size at end", k), model_q[k].size(), 0);
    end
    if (stall_count == 0) begin
      failure_count++;
      $display("error: random back-pressure never filled an input buffer");
    end

    $display("checks %0d, mismatches %0d, other errors %0d",
             check_count, mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    #(timeout_cycles_lp * clk_period_lp);
    $display("error: watchdog expired after %0d cycles, traffic did not drain",
             timeout_cycles_lp);
    $display("*** FAILED ***");
    $finish;
  end

endmodule
